/* src/vec_cmp_pkg.sv */
package vec_cmp_pkg;

    // float word layout
    localparam int FLOAT_W = 32;
    localparam int EXP_W = 8;
    localparam int MANT_W = 23;

    // vector shape and pipeline depth
    localparam int N_COMP = 3;
    localparam int PIPE_LATENCY = 2;

    typedef enum logic [1:0] {
        OP_HMAX = 2'd0,
        OP_HMIN = 2'd1,
        OP_VMAX = 2'd2,
        OP_VMIN = 2'd3
    } vec_op_e;

    // ieee-754 single precision fields
    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [MANT_W-1:0] mant;
    } float_fields_t;

    // raw bits for moving, fields for comparing
    typedef union packed {
        logic [FLOAT_W-1:0] bits;
        float_fields_t      fields;
    } float_word_u;

    typedef struct packed {
        float_word_u x;
        float_word_u y;
        float_word_u z;
    } vec3_t;

    // b is ignored by the horizontal ops
    typedef struct packed {
        vec_op_e op;
        vec3_t   a;
        vec3_t   b;
    } cmp_req_t;

    // beats[i] set means the later candidate of pair i wins
    typedef struct packed {
        vec_op_e           op;
        logic [N_COMP-1:0] beats;
        vec3_t             a;
        vec3_t             b;
    } cmp_flags_t;

endpackage

/* src/float_lt.sv */
`timescale 1ns/1ps

module float_lt (
    input  vec_cmp_pkg::float_word_u a,
    input  vec_cmp_pkg::float_word_u b,
    output logic                     lt
);

    logic [vec_cmp_pkg::EXP_W+vec_cmp_pkg::MANT_W-1:0] a_mag;
    logic [vec_cmp_pkg::EXP_W+vec_cmp_pkg::MANT_W-1:0] b_mag;
    logic both_zero;

    // exponent above mantissa, so magnitude orders as an unsigned number
    assign a_mag = {a.fields.exp, a.fields.mant};
    assign b_mag = {b.fields.exp, b.fields.mant};

    // +0 and -0 are equal
    assign both_zero = (a_mag == '0) && (b_mag == '0);

    always_comb begin
        if (both_zero) begin
            lt = 1'b0;
        end else if (a.fields.sign != b.fields.sign) begin
            // negative side is the smaller one
            lt = a.fields.sign;
        end else if (!a.fields.sign) begin
            lt = (a_mag < b_mag);
        end else begin
            // both negative, larger magnitude is smaller
            lt = (a_mag > b_mag);
        end
    end

endmodule

/* src/vec_compare_stage.sv */
`timescale 1ns/1ps

module vec_compare_stage (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    req_valid,
    input  vec_cmp_pkg::cmp_req_t   req,
    output logic                    flags_valid,
    output vec_cmp_pkg::cmp_flags_t flags
);

    // operand components indexed 0..2 as x, y, z
    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] a_c;
    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] b_c;

    // earlier candidate on lhs, later on rhs
    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] lhs;
    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] rhs;

    logic [vec_cmp_pkg::N_COMP-1:0] beats;

    assign a_c[0] = req.a.x;
    assign a_c[1] = req.a.y;
    assign a_c[2] = req.a.z;
    assign b_c[0] = req.b.x;
    assign b_c[1] = req.b.y;
    assign b_c[2] = req.b.z;

    // pair routing per opcode
    always_comb begin
        lhs = a_c;
        rhs = b_c;
        case (req.op)
            vec_cmp_pkg::OP_HMAX: begin
                // x<y, x<z, y<z
                lhs[0] = a_c[0];
                rhs[0] = a_c[1];
                lhs[1] = a_c[0];
                rhs[1] = a_c[2];
                lhs[2] = a_c[1];
                rhs[2] = a_c[2];
            end
            vec_cmp_pkg::OP_HMIN: begin
                // y<x, z<x, z<y
                lhs[0] = a_c[1];
                rhs[0] = a_c[0];
                lhs[1] = a_c[2];
                rhs[1] = a_c[0];
                lhs[2] = a_c[2];
                rhs[2] = a_c[1];
            end
            vec_cmp_pkg::OP_VMAX: begin
                lhs = a_c;
                rhs = b_c;
            end
            vec_cmp_pkg::OP_VMIN: begin
                lhs = b_c;
                rhs = a_c;
            end
        endcase
    end

    for (genvar i = 0; i < vec_cmp_pkg::N_COMP; i++) begin : g_lt
        float_lt float_lt_i (
            .a  (lhs[i]),
            .b  (rhs[i]),
            .lt (beats[i])
        );
    end

    // flags travel with both operands into the select stage
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            flags_valid <= 1'b0;
            flags <= '0;
        end else if (req_valid) begin
            flags_valid <= 1'b1;
            flags.op <= req.op;
            flags.beats <= beats;
            flags.a <= req.a;
            flags.b <= req.b;
        end else begin
            flags_valid <= 1'b0;
            flags <= '0;
        end
    end

endmodule

/* src/vec_select_stage.sv */
`timescale 1ns/1ps

module vec_select_stage (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    flags_valid,
    input  vec_cmp_pkg::cmp_flags_t flags,
    output logic                    res_valid,
    output vec_cmp_pkg::vec3_t      res
);

    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] a_c;
    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] b_c;
    vec_cmp_pkg::float_word_u [vec_cmp_pkg::N_COMP-1:0] pick_c;

    vec_cmp_pkg::float_word_u h_pick;
    vec_cmp_pkg::vec3_t       res_next;
    logic                     is_horiz;

    assign a_c[0] = flags.a.x;
    assign a_c[1] = flags.a.y;
    assign a_c[2] = flags.a.z;
    assign b_c[0] = flags.b.x;
    assign b_c[1] = flags.b.y;
    assign b_c[2] = flags.b.z;

    assign is_horiz = (flags.op == vec_cmp_pkg::OP_HMAX) ||
                      (flags.op == vec_cmp_pkg::OP_HMIN);

    // horizontal winner, ties fall to the lowest index
    always_comb begin
        if (!flags.beats[0] && !flags.beats[1]) begin
            h_pick = a_c[0];
        end else if (!flags.beats[2]) begin
            h_pick = a_c[1];
        end else begin
            h_pick = a_c[2];
        end
    end

    // component-wise winner, ties keep a
    always_comb begin
        for (int i = 0; i < vec_cmp_pkg::N_COMP; i++) begin
            pick_c[i] = flags.beats[i] ? b_c[i] : a_c[i];
        end
    end

    always_comb begin
        res_next = '0;
        if (is_horiz) begin
            res_next.x = h_pick;
        end else begin
            res_next.x = pick_c[0];
            res_next.y = pick_c[1];
            res_next.z = pick_c[2];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            res_valid <= 1'b0;
            res <= '0;
        end else if (flags_valid) begin
            res_valid <= 1'b1;
            res <= res_next;
        end else begin
            // idle cycles read as zero
            res_valid <= 1'b0;
            res <= '0;
        end
    end

endmodule

/* src/vec_cmp_top.sv */
`timescale 1ns/1ps

module vec_cmp_top (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  req_valid,
    input  vec_cmp_pkg::cmp_req_t req,
    output logic                  res_valid,
    output vec_cmp_pkg::vec3_t    res
);

    // stage 1 to stage 2
    logic                    flags_valid;
    vec_cmp_pkg::cmp_flags_t flags;

    // compare three pairs
    vec_compare_stage compare_stage_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .req_valid   (req_valid),
        .req         (req),
        .flags_valid (flags_valid),
        .flags       (flags)
    );

    // pick winners from the flags
    vec_select_stage select_stage_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .flags_valid (flags_valid),
        .flags       (flags),
        .res_valid   (res_valid),
        .res         (res)
    );

endmodule

/* verification/vec_cmp_model.svh */
`ifndef VEC_CMP_MODEL_SVH
`define VEC_CMP_MODEL_SVH

// unsigned scale that follows numeric order
// zero of either sign lands on the midpoint
function automatic logic [32:0] order_key(logic [31:0] f);
    logic [32:0] mag;
    mag = {2'b00, f[30:0]};
    if (f[31]) begin
        return 33'h080000000 - mag;
    end
    return 33'h080000000 + mag;
endfunction

function automatic bit is_less(logic [31:0] a, logic [31:0] b);
    return order_key(a) < order_key(b);
endfunction

function automatic vec_cmp_pkg::vec3_t expect_result(vec_cmp_pkg::cmp_req_t r);
    logic [31:0] a [3];
    logic [31:0] b [3];
    logic [31:0] w [3];
    logic [31:0] best;
    vec_cmp_pkg::vec3_t res;
    a[0] = r.a.x.bits;
    a[1] = r.a.y.bits;
    a[2] = r.a.z.bits;
    b[0] = r.b.x.bits;
    b[1] = r.b.y.bits;
    b[2] = r.b.z.bits;
    res = '0;
    if (r.op == vec_cmp_pkg::OP_HMAX || r.op == vec_cmp_pkg::OP_HMIN) begin
        // strict replacement keeps the lowest index on ties
        best = a[0];
        for (int i = 1; i < 3; i++) begin
            if (r.op == vec_cmp_pkg::OP_HMAX && is_less(best, a[i])) begin
                best = a[i];
            end else if (r.op == vec_cmp_pkg::OP_HMIN && is_less(a[i], best)) begin
                best = a[i];
            end
        end
        res.x.bits = best;
    end else begin
        for (int i = 0; i < 3; i++) begin
            if (r.op == vec_cmp_pkg::OP_VMAX) begin
                w[i] = is_less(a[i], b[i]) ? b[i] : a[i];
            end else begin
                w[i] = is_less(b[i], a[i]) ? b[i] : a[i];
            end
        end
        res.x.bits = w[0];
        res.y.bits = w[1];
        res.z.bits = w[2];
    end
    return res;
endfunction

`endif

/* verification/tb_vec_cmp.sv */
`timescale 1ns/1ps

module tb_vec_cmp;

    typedef struct packed {
        vec_cmp_pkg::vec3_t res;
        int                 due;
    } exp_entry_t;

    localparam int DRAIN_LIMIT = 50;

    logic                  clk_in;
    logic                  rst_in;
    logic                  req_valid;
    vec_cmp_pkg::cmp_req_t req;
    logic                  res_valid;
    vec_cmp_pkg::vec3_t    res;

    exp_entry_t expected_q[$];
    int         cycle = 0;
    int         checks = 0;
    int         errors = 0;
    int         tests = 0;
    int         test_checks;
    int         test_errors;
    string      test_name = "reset_idle";

    `include "vec_cmp_model.svh"

    vec_cmp_top vec_cmp_top_i (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req       (req),
        .res_valid (res_valid),
        .res       (res)
    );

    always #5 clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle <= cycle + 1;
    end

    // values that force ties, signed zeros and infinities
    function automatic logic [31:0] pool_value(int unsigned idx);
        case (idx)
            0: return 32'h0000_0000;
            1: return 32'h8000_0000;
            2: return 32'h3f80_0000;
            3: return 32'hbf80_0000;
            4: return 32'h4020_0000;
            5: return 32'hc020_0000;
            6: return 32'h7f80_0000;
            7: return 32'hff80_0000;
            default: return 32'h0040_0000;
        endcase
    endfunction

    function automatic logic [31:0] rand_float();
        logic [31:0] pick;
        logic [31:0] bits;
        pick = $urandom;
        if (pick[0]) begin
            return pool_value($urandom % 9);
        end
        bits = $urandom;
        // keep clear of the nan exponent
        if (bits[30:23] == 8'hff) begin
            bits[30:23] = 8'hfe;
        end
        return bits;
    endfunction

    function automatic vec_cmp_pkg::cmp_req_t rand_req(vec_cmp_pkg::vec_op_e op);
        vec_cmp_pkg::cmp_req_t r;
        r.op = op;
        r.a.x.bits = rand_float();
        r.a.y.bits = rand_float();
        r.a.z.bits = rand_float();
        r.b.x.bits = rand_float();
        r.b.y.bits = rand_float();
        r.b.z.bits = rand_float();
        return r;
    endfunction

    function automatic vec_cmp_pkg::vec_op_e rand_op();
        logic [31:0] tmp;
        tmp = $urandom;
        return vec_cmp_pkg::vec_op_e'(tmp[1:0]);
    endfunction

    // +0 against -0, then opposite signs
    function automatic vec_cmp_pkg::cmp_req_t signed_pair_req(vec_cmp_pkg::vec_op_e op,
                                                              bit swap);
        vec_cmp_pkg::vec3_t    p;
        vec_cmp_pkg::vec3_t    n;
        vec_cmp_pkg::cmp_req_t r;
        p.x.bits = 32'h0000_0000;
        p.y.bits = 32'hbf80_0000;
        p.z.bits = 32'h4020_0000;
        n.x.bits = 32'h8000_0000;
        n.y.bits = 32'h3f80_0000;
        n.z.bits = 32'hc020_0000;
        r.op = op;
        r.a = swap ? n : p;
        r.b = swap ? p : n;
        return r;
    endfunction

    task automatic drive_req(input logic valid, input vec_cmp_pkg::cmp_req_t r);
        @(posedge clk_in);
        req_valid <= valid;
        req <= r;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        int waited;
        drive_req(1'b0, rand_req(rand_op()));
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk_in);
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("error %s: timed out with %0d results still outstanding",
                     test_name, expected_q.size());
            errors++;
            expected_q.delete();
        end
        tests++;
        $display("test %s: %0d checks, %0d errors", test_name,
                 checks - test_checks, errors - test_errors);
    endtask

    // scoreboard, sampled mid-cycle where everything is settled
    always @(negedge clk_in) begin
        exp_entry_t e;
        if (res_valid) begin
            if (expected_q.size() == 0) begin
                $display("error %s: result arrived with no request outstanding", test_name);
                errors++;
            end else begin
                e = expected_q.pop_front();
                checks++;
                if (e.due != cycle) begin
                    $display("mismatch %s latency: expected cycle %0d, actual cycle %0d",
                             test_name, e.due, cycle);
                    errors++;
                end
                if (res !== e.res) begin
                    $display("mismatch %s: expected %h, actual %h", test_name, e.res, res);
                    errors++;
                end
            end
        end else begin
            checks++;
            if (res !== '0) begin
                $display("mismatch %s idle res: expected %h, actual %h", test_name,
                         96'h0, res);
                errors++;
            end
            if (expected_q.size() != 0 && expected_q[0].due <= cycle) begin
                $display("error %s: result missing at cycle %0d", test_name, cycle);
                errors++;
                e = expected_q.pop_front();
            end
        end
        if (req_valid && !rst_in) begin
            e.res = expect_result(req);
            e.due = cycle + vec_cmp_pkg::PIPE_LATENCY;
            expected_q.push_back(e);
        end
    end

    initial begin
        logic [31:0] gap;
        void'($urandom(66));
        clk_in = 1'b0;
        rst_in = 1'b1;
        req_valid = 1'b0;
        req = '0;

        begin_test("reset_idle");
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;
        for (int n = 0; n < 8; n++) begin
            drive_req(1'b0, rand_req(rand_op()));
        end
        end_test();

        begin_test("hmax_random");
        for (int n = 0; n < 40; n++) begin
            drive_req(1'b1, rand_req(vec_cmp_pkg::OP_HMAX));
        end
        end_test();

        begin_test("hmin_random");
        for (int n = 0; n < 40; n++) begin
            drive_req(1'b1, rand_req(vec_cmp_pkg::OP_HMIN));
        end
        end_test();

        begin_test("vec_minmax");
        for (int s = 0; s < 2; s++) begin
            drive_req(1'b1, signed_pair_req(vec_cmp_pkg::OP_VMAX, s == 1));
            drive_req(1'b1, signed_pair_req(vec_cmp_pkg::OP_VMIN, s == 1));
        end
        for (int n = 0; n < 40; n++) begin
            gap = $urandom;
            drive_req(1'b1, rand_req(gap[0] ? vec_cmp_pkg::OP_VMAX : vec_cmp_pkg::OP_VMIN));
        end
        end_test();

        begin_test("mixed_stream");
        for (int n = 0; n < 60; n++) begin
            drive_req(1'b1, rand_req(rand_op()));
        end
        end_test();

        // idle beats still carry junk data
        begin_test("gap_stream");
        for (int n = 0; n < 60; n++) begin
            gap = $urandom;
            drive_req(gap[0], rand_req(rand_op()));
        end
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+verification
src/vec_cmp_pkg.sv
src/float_lt.sv
src/vec_compare_stage.sv
src/vec_select_stage.sv
src/vec_cmp_top.sv
verification/tb_vec_cmp.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vec_cmp testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tb_vec_cmp -f project.f -o sim_tb \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "run reported failure"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
